// ==== all.f ====
mips_pkg.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
memory_arbiter.sv
cpu_top.sv
cpu_props.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: mips_subset_core

sources:
  - mips_pkg.sv
  - register_file.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - memory_arbiter.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_props.sv
      - tb_cpu.sv

// ==== tb_cpu.sv ====
// ####################
// random-program testbench for the MIPS subset core
// stores checked against an ISA model
// ####################
`default_nettype none

module tb_cpu;

	localparam int MEM_WORDS = 1024;
	localparam int BODY_LEN = 64;
	localparam int DATA_BASE = 32'h800;
	localparam int DATA_WORDS = 16;
	localparam int DUMP_BASE = 32'h900;
	localparam int WAIT_SLOTS = 256;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_INSTR = 40;
	localparam int unsigned SEED = 32'h2635_0ebc;

	// standard MIPS codes with HALT as all ones
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] OP_HALT = 6'h3f;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	logic CLK = 1'b0;
	logic nRST;
	logic mem_ren, mem_wen, mem_ready, halt;
	logic [31:0] mem_addr, mem_store, mem_load;

	// shared program and data memory and the model's copy
	logic [31:0] mem [MEM_WORDS];
	logic [31:0] ref_mem [MEM_WORDS];
	logic [31:0] ref_regs [32];
	logic [31:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	int unsigned wait_tab [WAIT_SLOTS];
	int prog_len = BODY_LEN + 9;
	int exec_count;
	bit prog_ready = 1'b0;

	// memory model state
	bit busy = 1'b0;
	bit halt_seen = 1'b0;
	logic req_write;
	logic [31:0] req_addr;
	int unsigned wait_left;
	int wait_idx = 0;

	cpu_top DUT (
		.CLK(CLK),
		.nRST(nRST),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_store(mem_store),
		.mem_load(mem_load),
		.mem_ready(mem_ready),
		.halt(halt)
	);

	always #2 CLK = ~CLK;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	function automatic int pick_reg();
		return $urandom_range(7, 0);
	endfunction

	function automatic logic [5:0] funct_for(input int k);
		case (k)
			0: return FN_ADDU;
			1: return FN_SUBU;
			2: return FN_AND;
			3: return FN_OR;
			default: return FN_SLT;
		endcase
	endfunction

	function automatic logic [31:0] encode_rtype(input logic [5:0] fn, input int rd, rs, rt);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] encode_itype(input logic [5:0] op, input int rs, rt,
			input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [15:0] window_addr();
		return 16'(DATA_BASE + 4 * $urandom_range(DATA_WORDS - 1, 0));
	endfunction

	task automatic fill_memory();
		// pattern tied to the full word address
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {~i[15:0], i[15:0]};
		end
		for (int i = 0; i < DATA_WORDS; i++) begin
			mem[DATA_BASE / 4 + i] = $urandom();
		end
	endtask

	task automatic build_program();
		int idx;
		int kind;
		int rs, rt, rd;
		idx = 0;
		while (idx < BODY_LEN) begin
			kind = $urandom_range(99, 0);
			rs = pick_reg();
			rt = pick_reg();
			rd = pick_reg();
			if ((kind >= 85) && (idx + 3 < BODY_LEN)) begin
				// forward skip of 1 to 3 instructions
				// operands made equal now and then
				if ($urandom_range(2, 0) == 0) begin
					rt = rs;
				end
				mem[idx] = encode_itype(OP_BEQ, rs, rt, 16'($urandom_range(3, 1)));
			end else if (kind < 35) begin
				mem[idx] = encode_rtype(funct_for($urandom_range(4, 0)), rd, rs, rt);
			end else if (kind < 55) begin
				mem[idx] = encode_itype(OP_ADDIU, rs, rt, 16'($urandom()));
			end else if (kind < 70) begin
				mem[idx] = encode_itype(OP_LW, 0, rt, window_addr());
				// often the loaded value is used at once
				if ((idx + 1 < BODY_LEN) && ($urandom_range(1, 0) == 1)) begin
					idx++;
					mem[idx] = encode_rtype(FN_ADDU, rd, rt, pick_reg());
				end
			end else if (kind < 85) begin
				mem[idx] = encode_itype(OP_SW, 0, rt, window_addr());
			end else begin
				mem[idx] = encode_rtype(funct_for($urandom_range(4, 0)), rd, rs, rt);
			end
			idx++;
		end
		// dump every register and stop
		for (int r = 0; r < 8; r++) begin
			mem[BODY_LEN + r] = encode_itype(OP_SW, 0, r, 16'(DUMP_BASE + 4 * r));
		end
		mem[BODY_LEN + 8] = {OP_HALT, 26'd0};
	endtask

	task automatic write_model_reg(input logic [4:0] r, input logic [31:0] val);
		if (r != 5'd0) begin
			ref_regs[r] = val;
		end
	endtask

	// instruction-level model with one instruction per loop pass
	task automatic run_model();
		logic [31:0] pc, ins, a, b, imm, addr, res;
		bit done;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = mem[i];
		end
		pc = '0;
		done = 1'b0;
		exec_count = 0;
		while (!done) begin
			ins = ref_mem[pc / 4];
			a = ref_regs[ins[25:21]];
			b = ref_regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			pc = pc + 32'd4;
			exec_count++;
			case (ins[31:26])
				OP_RTYPE: begin
					case (ins[5:0])
						FN_ADDU: res = a + b;
						FN_SUBU: res = a - b;
						FN_AND: res = a & b;
						FN_OR: res = a | b;
						default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
					write_model_reg(ins[15:11], res);
				end
				OP_ADDIU: write_model_reg(ins[20:16], a + imm);
				OP_LW: write_model_reg(ins[20:16], ref_mem[(a + imm) / 4]);
				OP_SW: begin
					addr = a + imm;
					ref_mem[addr / 4] = b;
					exp_addr_q.push_back(addr);
					exp_data_q.push_back(b);
				end
				OP_BEQ: begin
					if (a == b) begin
						pc = pc + (imm << 2);
					end
				end
				default: done = 1'b1;
			endcase
		end
	endtask

	// completes the access in the current cycle
	task automatic serve_access();
		if (mem_addr[31:2] >= MEM_WORDS) begin
			abort_run("memory access outside the memory array");
		end
		if (mem_wen) begin
			if (exp_addr_q.size() == 0) begin
				abort_run("store seen after all expected stores were done");
			end
			check_value("mem_addr", mem_addr, exp_addr_q.pop_front());
			check_value("mem_store", mem_store, exp_data_q.pop_front());
			mem[mem_addr[31:2]] = mem_store;
		end else begin
			mem_load = mem[mem_addr[31:2]];
		end
		mem_ready = 1'b1;
	endtask

	// memory port with 0 to 3 wait states driven just after the edge
	always begin
		@(posedge CLK);
		#1;
		mem_ready = 1'b0;
		if (halt_seen && (halt !== 1'b1)) begin
			abort_run("halt fell after it had been raised");
		end
		if (halt === 1'b1) begin
			halt_seen = 1'b1;
			if ((mem_ren !== 1'b0) || (mem_wen !== 1'b0)) begin
				abort_run("memory request raised while halted");
			end
		end
		if ((mem_ren === 1'b1) && (mem_wen === 1'b1)) begin
			abort_run("read and write requested in the same cycle");
		end
		if ((mem_ren === 1'b1) || (mem_wen === 1'b1)) begin
			if (!busy) begin
				busy = 1'b1;
				req_write = mem_wen;
				req_addr = mem_addr;
				wait_left = wait_tab[wait_idx];
				wait_idx = (wait_idx + 1) % WAIT_SLOTS;
			end else if ((mem_wen !== req_write) || (mem_addr !== req_addr)) begin
				abort_run("memory request changed before mem_ready");
			end
			if (wait_left == 0) begin
				serve_access();
				busy = 1'b0;
			end else begin
				wait_left--;
			end
		end else if (busy) begin
			abort_run("memory request dropped before mem_ready");
		end
	end

	// watchdog budget scales with program length
	initial begin
		wait (prog_ready);
		repeat (RESET_CYCLES + prog_len * CYCLES_PER_INSTR) @(posedge CLK);
		abort_run("timeout, the core did not halt within the cycle budget");
	end

	initial begin
		nRST = 1'b0;
		mem_ready = 1'b0;
		mem_load = '0;
		void'($urandom(SEED));
		fill_memory();
		build_program();
		run_model();
		for (int i = 0; i < WAIT_SLOTS; i++) begin
			wait_tab[i] = $urandom_range(3, 0);
		end
		$display("program of %0d words, %0d executed, %0d stores expected",
			prog_len, exec_count, exp_addr_q.size());
		prog_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		nRST = 1'b1;
		while (halt !== 1'b1) begin
			@(posedge CLK);
			#1;
		end
		// port must stay quiet from here on
		repeat (10) @(posedge CLK);
		if (exp_addr_q.size() != 0) begin
			abort_run("expected stores missing at the end of the run");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== cpu_props.sv ====
// ####################
// memory port and halt properties, bound into the core top level
// ####################
`default_nettype none

module cpu_props (
	input logic CLK,
	input logic nRST,
	input logic mem_ren,
	input logic mem_wen,
	input logic [31:0] mem_addr,
	input logic [31:0] mem_store,
	input logic mem_ready,
	input logic halt
);

	// one direction at a time
	a_one_request: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_ren && mem_wen))
		else $error("mem_ren and mem_wen high together");

	// request held until the ready cycle
	a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_ren || mem_wen) && !mem_ready |=>
		$stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr)
		&& (!mem_wen || $stable(mem_store)))
		else $error("memory request changed before mem_ready");

	// sticky halt
	a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		halt |=> halt)
		else $error("halt fell");

	a_quiet_halt: assert property (@(posedge CLK) disable iff (!nRST)
		halt |-> !mem_ren && !mem_wen)
		else $error("memory request while halted");

endmodule

bind cpu_top cpu_props u_props (
	.CLK(CLK),
	.nRST(nRST),
	.mem_ren(mem_ren),
	.mem_wen(mem_wen),
	.mem_addr(mem_addr),
	.mem_store(mem_store),
	.mem_ready(mem_ready),
	.halt(halt)
);

`default_nettype wire

// ==== cpu_top.sv ====
// ##################
// five-stage MIPS subset core on one shared memory port
// ##################
`default_nettype none

module cpu_top import mips_pkg::*; #(
	parameter word_t PC_INIT = '0
) (
	input logic CLK,
	input logic nRST,
	output logic mem_ren,
	output logic mem_wen,
	output word_t mem_addr,
	output word_t mem_store,
	input word_t mem_load,
	input logic mem_ready,
	output logic halt
);

	logic advance, stall, branch_taken;
	word_t pc, instr_word, load_word, branch_target;
	word_t if_instr, if_pc;
	// decode to execute
	word_t ex_a, ex_b, ex_imm, ex_pc;
	reg_addr_t ex_rs, ex_rt, ex_dest;
	aluop_t ex_aluop;
	logic ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_halt;
	// execute to memory
	word_t mem_result, mem_store_data;
	reg_addr_t mem_dest;
	logic mem_reg_write, mem_read, mem_write, mem_halt;
	// memory to arbiter and write-back
	logic data_ren, data_wen, wb_en;
	word_t data_addr, data_store, wb_data;
	reg_addr_t wb_dest;

	fetch_stage #(.PC_INIT(PC_INIT)) u_fetch (
		.CLK(CLK), .nRST(nRST), .advance(advance), .instr_word(instr_word),
		.stall(stall), .branch_taken(branch_taken), .branch_target(branch_target),
		.pc(pc), .if_instr(if_instr), .if_pc(if_pc)
	);

	decode_stage u_decode (
		.CLK(CLK), .nRST(nRST), .advance(advance), .if_instr(if_instr), .if_pc(if_pc),
		.branch_taken(branch_taken), .wb_en(wb_en), .wb_dest(wb_dest), .wb_data(wb_data),
		.stall(stall), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm), .ex_pc(ex_pc),
		.ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dest(ex_dest), .ex_aluop(ex_aluop),
		.ex_use_imm(ex_use_imm), .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write), .ex_branch(ex_branch), .ex_halt(ex_halt)
	);

	execute_stage u_execute (
		.CLK(CLK), .nRST(nRST), .advance(advance), .ex_a(ex_a), .ex_b(ex_b),
		.ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dest(ex_dest),
		.ex_aluop(ex_aluop), .ex_use_imm(ex_use_imm), .ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write), .ex_branch(ex_branch),
		.ex_halt(ex_halt), .mem_result(mem_result), .mem_dest(mem_dest),
		.mem_reg_write(mem_reg_write), .mem_read(mem_read), .mem_write(mem_write),
		.mem_halt(mem_halt), .mem_store_data(mem_store_data), .wb_en(wb_en),
		.wb_dest(wb_dest), .wb_data(wb_data), .branch_taken(branch_taken),
		.branch_target(branch_target)
	);

	memory_stage u_memory (
		.CLK(CLK), .nRST(nRST), .advance(advance), .mem_result(mem_result),
		.mem_dest(mem_dest), .mem_reg_write(mem_reg_write), .mem_read(mem_read),
		.mem_write(mem_write), .mem_halt(mem_halt), .mem_store_data(mem_store_data),
		.load_word(load_word), .data_ren(data_ren), .data_wen(data_wen),
		.data_addr(data_addr), .data_store(data_store), .wb_en(wb_en),
		.wb_dest(wb_dest), .wb_data(wb_data), .halt(halt)
	);

	memory_arbiter u_arbiter (
		.CLK(CLK), .nRST(nRST), .data_ren(data_ren), .data_wen(data_wen),
		.data_addr(data_addr), .data_store(data_store), .pc(pc), .halt(halt),
		.mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_store(mem_store),
		.mem_load(mem_load), .mem_ready(mem_ready), .instr_word(instr_word),
		.load_word(load_word), .advance(advance)
	);

endmodule

`default_nettype wire

// ==== memory_arbiter.sv ====
// ##################
// shared memory port arbiter, data first then fetch
// ##################
`default_nettype none

module memory_arbiter import mips_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic data_ren,
	input logic data_wen,
	input word_t data_addr,
	input word_t data_store,
	input word_t pc,
	input logic halt,
	output logic mem_ren,
	output logic mem_wen,
	output word_t mem_addr,
	output word_t mem_store,
	input word_t mem_load,
	input logic mem_ready,
	output word_t instr_word,
	output word_t load_word,
	output logic advance
);

	arb_state_t state, state_next;
	logic data_req;

	assign data_req = data_ren || data_wen;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= ARB_DATA;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			// skip straight on when there is no data access
			ARB_DATA: if (!data_req || mem_ready) state_next = ARB_INSTR;
			ARB_INSTR: if (mem_ready) state_next = ARB_DONE;
			default: state_next = ARB_DATA;
		endcase
		// frozen once halted
		if (halt) begin
			state_next = state;
		end
	end

	assign mem_ren = !halt && (((state == ARB_DATA) && data_ren) || (state == ARB_INSTR));
	assign mem_wen = !halt && (state == ARB_DATA) && data_wen;
	assign mem_addr = (state == ARB_DATA) ? data_addr : pc;
	assign mem_store = data_store;

	// returned words held until the stage latches take them
	always_ff @(posedge CLK) begin
		if ((state == ARB_DATA) && data_ren && mem_ready) begin
			load_word <= mem_load;
		end
		if ((state == ARB_INSTR) && mem_ready) begin
			instr_word <= mem_load;
		end
	end

	// one cycle after the last ready of the step
	assign advance = (state == ARB_DONE) && !halt;

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
// ##################
// memory: data request, memory/write-back latch, halt flag
// ##################
`default_nettype none

module memory_stage import mips_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic advance,
	input word_t mem_result,
	input reg_addr_t mem_dest,
	input logic mem_reg_write,
	input logic mem_read,
	input logic mem_write,
	input logic mem_halt,
	input word_t mem_store_data,
	input word_t load_word,
	output logic data_ren,
	output logic data_wen,
	output word_t data_addr,
	output word_t data_store,
	output logic wb_en,
	output reg_addr_t wb_dest,
	output word_t wb_data,
	output logic halt
);

	logic wb_is_load;
	word_t wb_load, wb_alu;

	// no data traffic once stopped
	assign data_ren = mem_read && !halt;
	assign data_wen = mem_write && !halt;
	assign data_addr = mem_result;
	assign data_store = mem_store_data;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_en <= 1'b0;
			wb_dest <= '0;
			wb_is_load <= 1'b0;
			wb_load <= '0;
			wb_alu <= '0;
		end else if (advance) begin
			wb_en <= mem_reg_write;
			wb_dest <= mem_dest;
			wb_is_load <= mem_read;
			wb_load <= load_word;
			wb_alu <= mem_result;
		end
	end

	assign wb_data = wb_is_load ? wb_load : wb_alu;

	// sticky, set the cycle after HALT lands here
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			halt <= 1'b0;
		end else if (mem_halt) begin
			halt <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
// ##################
// execute: forwarding, ALU, BEQ resolution, execute/memory latch
// ##################
`default_nettype none

module execute_stage import mips_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic advance,
	input word_t ex_a,
	input word_t ex_b,
	input word_t ex_imm,
	input word_t ex_pc,
	input reg_addr_t ex_rs,
	input reg_addr_t ex_rt,
	input reg_addr_t ex_dest,
	input aluop_t ex_aluop,
	input logic ex_use_imm,
	input logic ex_reg_write,
	input logic ex_mem_read,
	input logic ex_mem_write,
	input logic ex_branch,
	input logic ex_halt,
	output word_t mem_result,
	output reg_addr_t mem_dest,
	output logic mem_reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic mem_halt,
	output word_t mem_store_data,
	input logic wb_en,
	input reg_addr_t wb_dest,
	input word_t wb_data,
	output logic branch_taken,
	output word_t branch_target
);

	fwd_sel_t sel_a, sel_b;
	word_t op_a, reg_b, op_b, result;

	// memory stage wins over write-back, loads there have no value yet
	function automatic fwd_sel_t pick_src(input reg_addr_t src);
		fwd_sel_t sel;
		sel = FWD_NONE;
		if (src != '0) begin
			if (mem_reg_write && !mem_read && (mem_dest == src)) begin
				sel = FWD_MEM;
			end else if (wb_en && (wb_dest == src)) begin
				sel = FWD_WB;
			end
		end
		return sel;
	endfunction

	function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t latched);
		word_t val;
		case (sel)
			FWD_MEM: val = mem_result;
			FWD_WB: val = wb_data;
			default: val = latched;
		endcase
		return val;
	endfunction

	assign sel_a = pick_src(ex_rs);
	assign sel_b = pick_src(ex_rt);
	assign op_a = fwd_mux(sel_a, ex_a);
	assign reg_b = fwd_mux(sel_b, ex_b);
	assign op_b = ex_use_imm ? ex_imm : reg_b;

	// ALU
	always_comb begin
		case (ex_aluop)
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR: result = op_a | op_b;
			ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
			default: result = op_a + op_b;
		endcase
	end

	// beq, target relative to the next pc
	assign branch_taken = ex_branch && (op_a == reg_b);
	assign branch_target = ex_pc + 32'd4 + {ex_imm[29:0], 2'b00};

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mem_result <= '0;
			mem_dest <= '0;
			mem_reg_write <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			mem_halt <= 1'b0;
			mem_store_data <= '0;
		end else if (advance) begin
			mem_result <= result;
			mem_dest <= ex_dest;
			mem_reg_write <= ex_reg_write;
			mem_read <= ex_mem_read;
			mem_write <= ex_mem_write;
			mem_halt <= ex_halt;
			// store data takes the forwarded rt
			mem_store_data <= reg_b;
		end
	end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
// ##################
// decode: control, register read, load-use check, decode/execute latch
// ##################
`default_nettype none

module decode_stage import mips_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic advance,
	input word_t if_instr,
	input word_t if_pc,
	input logic branch_taken,
	input logic wb_en,
	input reg_addr_t wb_dest,
	input word_t wb_data,
	output logic stall,
	output word_t ex_a,
	output word_t ex_b,
	output word_t ex_imm,
	output word_t ex_pc,
	output reg_addr_t ex_rs,
	output reg_addr_t ex_rt,
	output reg_addr_t ex_dest,
	output aluop_t ex_aluop,
	output logic ex_use_imm,
	output logic ex_reg_write,
	output logic ex_mem_read,
	output logic ex_mem_write,
	output logic ex_branch,
	output logic ex_halt
);

	opcode_t op;
	funct_t fn;
	reg_addr_t rs, rt, rd, dest;
	word_t imm_ext, rdat1, rdat2;
	aluop_t aluop;
	logic use_imm, reg_write, mem_read, mem_write, branch, is_halt;
	logic bubble;

	// field split
	assign op = opcode_t'(if_instr[OP_LSB +: $bits(opcode_t)]);
	assign fn = funct_t'(if_instr[FUNCT_LSB +: $bits(funct_t)]);
	assign rs = if_instr[RS_LSB +: $bits(reg_addr_t)];
	assign rt = if_instr[RT_LSB +: $bits(reg_addr_t)];
	assign rd = if_instr[RD_LSB +: $bits(reg_addr_t)];

	// sign extension of the 16 bit immediate
	assign imm_ext = {{(32 - IMM_W){if_instr[IMM_W - 1]}}, if_instr[IMM_W - 1:0]};

	register_file u_rf (
		.CLK(CLK),
		.nRST(nRST),
		.wen(wb_en),
		.wsel(wb_dest),
		.wdat(wb_data),
		.rsel1(rs),
		.rsel2(rt),
		.rdat1(rdat1),
		.rdat2(rdat2)
	);

	// control decode
	always_comb begin
		aluop = ALU_ADD;
		use_imm = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		is_halt = 1'b0;
		dest = rt;
		case (op)
			RTYPE: begin
				dest = rd;
				reg_write = 1'b1;
				case (fn)
					ADDU: aluop = ALU_ADD;
					SUBU: aluop = ALU_SUB;
					AND: aluop = ALU_AND;
					OR: aluop = ALU_OR;
					SLT: aluop = ALU_SLT;
					// unknown funct, incl. nop word
					default: reg_write = 1'b0;
				endcase
			end
			ADDIU: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			LW: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
			end
			SW: begin
				use_imm = 1'b1;
				mem_write = 1'b1;
			end
			BEQ: begin
				aluop = ALU_SUB;
				branch = 1'b1;
			end
			HALT: is_halt = 1'b1;
			default: ;
		endcase
	end

	// load in execute feeding this instruction
	assign stall = ex_mem_read && (ex_dest != '0) && ((ex_dest == rs) || (ex_dest == rt));

	// younger than a taken branch, or held back by the stall
	assign bubble = stall || branch_taken;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ex_a <= '0;
			ex_b <= '0;
			ex_imm <= '0;
			ex_pc <= '0;
			ex_rs <= '0;
			ex_rt <= '0;
			ex_dest <= '0;
			ex_aluop <= ALU_ADD;
			ex_use_imm <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_branch <= 1'b0;
			ex_halt <= 1'b0;
		end else if (advance) begin
			ex_a <= rdat1;
			ex_b <= rdat2;
			ex_imm <= imm_ext;
			ex_pc <= if_pc;
			ex_rs <= rs;
			ex_rt <= rt;
			ex_dest <= dest;
			ex_aluop <= aluop;
			ex_use_imm <= use_imm;
			// control cleared for a bubble
			ex_reg_write <= reg_write && !bubble;
			ex_mem_read <= mem_read && !bubble;
			ex_mem_write <= mem_write && !bubble;
			ex_branch <= branch && !bubble;
			ex_halt <= is_halt && !bubble;
		end
	end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
// ##################
// program counter and fetch/decode latch
// ##################
`default_nettype none

module fetch_stage import mips_pkg::*; #(
	parameter word_t PC_INIT = '0
) (
	input logic CLK,
	input logic nRST,
	input logic advance,
	input word_t instr_word,
	input logic stall,
	input logic branch_taken,
	input word_t branch_target,
	output word_t pc,
	output word_t if_instr,
	output word_t if_pc
);

	word_t pc_next;

	// sequential fetch address
	assign pc_next = pc + 32'd4;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= PC_INIT;
			if_instr <= NOP_WORD;
			if_pc <= PC_INIT;
		end else if (advance) begin
			if (branch_taken) begin
				// redirect, fetched word is wrong path
				pc <= branch_target;
				if_instr <= NOP_WORD;
				if_pc <= branch_target;
			end else if (stall) begin
				// load-use, refetch same pc next step
				pc <= pc;
				if_instr <= if_instr;
				if_pc <= if_pc;
			end else begin
				pc <= pc_next;
				if_instr <= instr_word;
				if_pc <= pc;
			end
		end
	end

endmodule

`default_nettype wire

// ==== register_file.sv ====
// ##################
// 32x32 register file, r0 fixed at zero, write-through reads
// ##################
`default_nettype none

module register_file import mips_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic wen,
	input reg_addr_t wsel,
	input word_t wdat,
	input reg_addr_t rsel1,
	input reg_addr_t rsel2,
	output word_t rdat1,
	output word_t rdat2
);

	word_t regs [32];

	// r0 never written
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (wsel != '0)) begin
			regs[wsel] <= wdat;
		end
	end

	// same-cycle write shows up on the read ports
	assign rdat1 = (wen && (wsel != '0) && (wsel == rsel1)) ? wdat : regs[rsel1];
	assign rdat2 = (wen && (wsel != '0) && (wsel == rsel2)) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

// ==== mips_pkg.sv ====
// ##################
// shared types and instruction fields for the MIPS subset core
// ##################
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes, HALT is all ones
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		BEQ   = 6'h04,
		ADDIU = 6'h09,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	// r-type function codes
	typedef enum logic [5:0] {
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluop_t;

	// operand source for execute
	typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;

	typedef enum logic [1:0] {ARB_DATA, ARB_INSTR, ARB_DONE} arb_state_t;

	// instruction field positions
	localparam int OP_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_W = 16;

	// bubble, decodes to nothing
	localparam word_t NOP_WORD = 32'h0000_0000;

endpackage

`default_nettype wire
